//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_vga_text
FILELIST  = src.f
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Passes only when the pass message shows up in the output.
run: build
	./obj_dir/V$(TOP) $(RUN_FLAGS) | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- glyphs.mem
// @address is a scancode, value is a 30 bit glyph, bit 29 top left.
// Six rows of five bits each, top row first, leftmost pixel in the high bit.
@1C 1D18FE31 // A
@32 3D1F463E // B
@21 1F08420F // C
@23 3D18C63E // D
@24 3F0F421F // E
@2B 3F0F4210 // F
@34 1F09C62F // G
@33 231FC631 // H
@43 1C42108E // I
@3B 0E210A4C // J
@42 232E4A31 // K
@4B 2108421F // L
@3A 23BAC631 // M
@31 239ACE31 // N
@44 1D18C62E // O
@4D 3D1F4210 // P
@15 1D18D64D // Q
@2D 3D1F5251 // R
@1B 1F07043E // S
@2C 3E421084 // T
@3C 2318C62E // U
@2A 2318C544 // V
@1D 2318D771 // W
@22 22A21151 // X
@35 22A21084 // Y
@1A 3E22221F // Z
@45 1D3AE62E // 0
@16 08C2108E // 1
@1E 1D11111F // 2
@26 3C17043E // 3
@25 04657C42 // 4
@2E 3F0F043E // 5
@36 1D0F462E // 6
@3D 3E111108 // 7
@3E 1D17462E // 8
@46 1D17842E // 9

//--- hdl/pixel_render.sv
`timescale 1ns/1ps

module pixel_render import vga_timing_pkg::*, text_pkg::*; (
	input  logic        VGA_CLK,
	input  logic        resetall,
	input  scan_pos_t   scan,
	input  colour_sel_t sw_back,
	input  colour_sel_t sw_letters,
	output cell_index_t rd_cell,
	input  scancode_t   rd_code,
	output rgb_t        rgb,
	output logic        hsync,
	output logic        vsync,
	output logic        blank
);

	typedef struct packed {
		logic        video_on;
		logic        hsync;
		logic        vsync;
		logic        in_grid;
		glyph_bit_t  bit_sel;
		colour_sel_t back;
		colour_sel_t letters;
	} stage1_t;

	glyph_t     glyph_rom [glyph_rom_depth];
	logic [2:0] glyph_col;
	logic [2:0] glyph_row;
	stage1_t    s1_next;
	stage1_t    s1;
	glyph_t     glyph;
	logic       lit;
	rgb_t       colour;

	function automatic rgb_t expand(input colour_sel_t sel);
		rgb_t c;
		c.r = sel[2] ? chan_full : '0;
		c.g = sel[1] ? chan_full : '0;
		c.b = sel[0] ? chan_full : '0;
		return c;
	endfunction

	// Entries not in the file stay blank.
	initial begin
		for (int i = 0; i < glyph_rom_depth; i++) begin
			glyph_rom[i] = '0;
		end
		$readmemh(glyph_file, glyph_rom);
	end

	// ##########################################################
	// Stage one. Cell read issued straight from the scan position.
	// ##########################################################
	assign rd_cell   = cell_index_t'(scan.v_count / cell_h * text_cols + scan.h_count / cell_w);
	assign glyph_col = 3'((scan.h_count % cell_w) / glyph_scale);
	assign glyph_row = 3'((scan.v_count % cell_h) / glyph_scale);

	always_comb begin
		s1_next.video_on = scan.video_on;
		s1_next.hsync    = scan.hsync;
		s1_next.vsync    = scan.vsync;
		s1_next.in_grid  = (scan.h_count < text_cols * cell_w) &&
		                   (scan.v_count < text_rows * cell_h);
		s1_next.bit_sel  = glyph_bit_t'(glyph_w * glyph_h - 1 - glyph_row * glyph_w - glyph_col);
		s1_next.back     = sw_back;
		s1_next.letters  = sw_letters;
	end

	always_ff @(posedge VGA_CLK) begin
		if (!resetall) s1 <= '{hsync: 1'b1, vsync: 1'b1, default: '0};
		else s1 <= s1_next;
	end

	// ##########################################################
	// Stage two. Glyph lookup on the returned code.
	// ##########################################################
	assign glyph  = glyph_rom[rd_code[6:0]];
	assign lit    = s1.in_grid && glyph[s1.bit_sel];
	assign colour = !s1.video_on ? '0 : (lit ? expand(s1.letters) : expand(s1.back));

	always_ff @(posedge VGA_CLK) begin
		if (!resetall) begin
			rgb   <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank <= 1'b0;
		end else begin
			rgb   <= colour;
			hsync <= s1.hsync;
			vsync <= s1.vsync;
			blank <= s1.video_on; // High on active video.
		end
	end

endmodule

//--- hdl/ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver import text_pkg::*; (
	input  logic      VGA_CLK,
	input  logic      resetall,
	input  logic      clockps2,
	input  logic      data,
	output key_byte_t rx_key
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       clk_prev;
	logic       fall;
	logic       last_bit;
	logic       frame_ok;
	logic [3:0] bit_cnt;
	logic [ps2_frame_bits-1:0] frame;
	logic [ps2_frame_bits-1:0] frame_next;
	logic       key_valid;
	scancode_t  key_code;

	// ##########################################################
	// Synchronisers and falling edge of the PS/2 clock.
	// ##########################################################
	always_ff @(posedge VGA_CLK) begin
		if (!resetall) begin
			clk_sync  <= 2'b11; // Idle high.
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], clockps2};
			data_sync <= {data_sync[0], data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign fall = clk_prev && !clk_sync[1];
	assign last_bit = (bit_cnt == 4'(ps2_frame_bits - 1));

	// LSB first, so the new bit enters at the top.
	assign frame_next = {data_sync[1], frame[ps2_frame_bits-1:1]};

	// Start low, stop high, odd parity over data and parity bit.
	assign frame_ok = !frame_next[0] && frame_next[ps2_frame_bits-1] && (^frame_next[9:1]);

	always_ff @(posedge VGA_CLK) begin
		if (!resetall) begin
			bit_cnt   <= '0;
			key_valid <= 1'b0;
		end else begin
			key_valid <= fall && last_bit && frame_ok;
			if (fall) begin
				bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge VGA_CLK) begin
		if (fall) begin
			frame <= frame_next;
		end
		if (fall && last_bit) begin
			key_code <= frame_next[8:1];
		end
	end

	assign rx_key = '{valid: key_valid, code: key_code};

endmodule

//--- hdl/text_buffer.sv
`timescale 1ns/1ps

module text_buffer import text_pkg::*; (
	input  logic        VGA_CLK,
	input  logic        resetall,
	input  key_byte_t   rx_key,
	input  cell_index_t rd_cell,
	output scancode_t   rd_code
);

	scancode_t   cells [text_cols*text_rows];
	cell_index_t cursor;
	logic        break_seen;

	// ##########################################################
	// Write side. Break codes and the byte after them are dropped.
	// ##########################################################
	always_ff @(posedge VGA_CLK) begin
		if (!resetall) begin
			break_seen <= 1'b0;
			cursor     <= '0;
			for (int i = 0; i < text_cols * text_rows; i++) begin
				cells[i] <= '0; // Blank glyph.
			end
		end else if (rx_key.valid) begin
			if (break_seen) begin
				break_seen <= 1'b0; // Released key.
			end else if (rx_key.code == break_code) begin
				break_seen <= 1'b1;
			end else begin
				cells[cursor] <= rx_key.code;
				cursor        <= cursor + 1'b1; // Wraps 63 to 0.
			end
		end
	end

	// Registered read for the renderer.
	always_ff @(posedge VGA_CLK) begin
		rd_code <= cells[rd_cell];
	end

endmodule

//--- hdl/text_pkg.sv
package text_pkg;

	// ##########################################################
	// Keyboard side.
	// ##########################################################
	typedef logic [7:0] scancode_t;

	typedef struct packed {
		logic      valid; // One-cycle strobe.
		scancode_t code;
	} key_byte_t;

	localparam scancode_t break_code = 8'hF0;
	localparam int ps2_frame_bits = 11; // Start, 8 data, parity, stop.

	// ##########################################################
	// Text grid and glyphs.
	// ##########################################################
	typedef logic [5:0] cell_index_t; // Row by row.

	localparam int text_cols   = 16;
	localparam int text_rows   = 4;
	localparam int glyph_scale = 5;
	localparam int glyph_w     = 5;
	localparam int glyph_h     = 6;
	localparam int cell_w      = glyph_w * glyph_scale;
	localparam int cell_h      = glyph_h * glyph_scale;

	// Bit 29 is top left, rows top first, MSB leftmost.
	typedef logic [glyph_w*glyph_h-1:0] glyph_t;
	typedef logic [4:0] glyph_bit_t;

	localparam int glyph_rom_depth = 128; // Low seven scancode bits.
	localparam string glyph_file = "glyphs.mem";

endpackage

//--- hdl/vga_text_top.sv
`timescale 1ns/1ps

module vga_text_top import vga_timing_pkg::*, text_pkg::*; (
	input  logic        VGA_CLK,
	input  logic        resetall,
	input  logic        clockps2,
	input  logic        data,
	input  colour_sel_t sw_back,
	input  colour_sel_t sw_letters,
	output chan_t       vga_r,
	output chan_t       vga_g,
	output chan_t       vga_b,
	output logic        vga_hs,
	output logic        vga_vs,
	output logic        vga_blank
);

	key_byte_t   rx_key;
	scan_pos_t   scan;
	cell_index_t rd_cell;
	scancode_t   rd_code;
	rgb_t        pix_rgb;

	// Keyboard path.
	ps2_receiver rx0 (.VGA_CLK, .resetall, .clockps2, .data, .rx_key);
	text_buffer buf0 (.VGA_CLK, .resetall, .rx_key, .rd_cell, .rd_code);

	// Display path.
	vga_timing tim0 (.VGA_CLK, .resetall, .scan);
	pixel_render ren0 (
		.VGA_CLK,
		.resetall,
		.scan,
		.sw_back,
		.sw_letters,
		.rd_cell,
		.rd_code,
		.rgb   (pix_rgb),
		.hsync (vga_hs),
		.vsync (vga_vs),
		.blank (vga_blank)
	);

	assign vga_r = pix_rgb.r;
	assign vga_g = pix_rgb.g;
	assign vga_b = pix_rgb.b;

endmodule

//--- hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing import vga_timing_pkg::*; (
	input  logic      VGA_CLK,
	input  logic      resetall,
	output scan_pos_t scan
);

	coord_t h_count;
	coord_t v_count;
	coord_t h_next;
	coord_t v_next;
	logic   video_on;
	logic   hsync;
	logic   vsync;
	logic   line_end;

	assign line_end = (h_count == h_total - 1'b1);

	always_comb begin
		h_next = line_end ? '0 : h_count + 1'b1;
		v_next = v_count;
		if (line_end) begin
			v_next = (v_count == v_total - 1'b1) ? '0 : v_count + 1'b1;
		end
	end

	// Flags are built from the next count so they line up with it.
	always_ff @(posedge VGA_CLK) begin
		if (!resetall) begin
			h_count  <= '0;
			v_count  <= '0;
			video_on <= 1'b1; // Position 0,0 is active.
			hsync    <= 1'b1;
			vsync    <= 1'b1;
		end else begin
			h_count  <= h_next;
			v_count  <= v_next;
			video_on <= (h_next < h_active) && (v_next < v_active);
			hsync    <= !((h_next >= h_sync_start) && (h_next <= h_sync_end));
			vsync    <= !((v_next >= v_sync_start) && (v_next <= v_sync_end));
		end
	end

	assign scan = '{
		h_count:  h_count,
		v_count:  v_count,
		video_on: video_on,
		hsync:    hsync,
		vsync:    vsync
	};

endmodule

//--- hdl/vga_timing_pkg.sv
package vga_timing_pkg;

	// ##########################################################
	// Raster types.
	// ##########################################################
	typedef logic [9:0] coord_t;
	typedef logic [9:0] chan_t;
	typedef logic [2:0] colour_sel_t; // Switch bits, r g b.

	// 640x480 raster, counts start at the first active pixel.
	localparam coord_t h_active     = 10'd640;
	localparam coord_t h_sync_start = 10'd656;
	localparam coord_t h_sync_end   = 10'd751; // Last low count.
	localparam coord_t h_total      = 10'd800;
	localparam coord_t v_active     = 10'd480;
	localparam coord_t v_sync_start = 10'd490;
	localparam coord_t v_sync_end   = 10'd491;
	localparam coord_t v_total      = 10'd525;

	localparam chan_t chan_full = 10'd1023;

	typedef struct packed {
		chan_t r;
		chan_t g;
		chan_t b;
	} rgb_t;

	typedef struct packed {
		coord_t h_count;
		coord_t v_count;
		logic   video_on;
		logic   hsync;
		logic   vsync;
	} scan_pos_t;

endpackage

//--- src.f
hdl/vga_timing_pkg.sv
hdl/text_pkg.sv
hdl/vga_timing.sv
hdl/ps2_receiver.sv
hdl/text_buffer.sv
hdl/pixel_render.sv
hdl/vga_text_top.sv
verification/vga_text_assert.sv
verification/tb_vga_text.sv

//--- verification/tb_vga_text.sv
`timescale 1ns/1ps

module tb_vga_text import vga_timing_pkg::*, text_pkg::*; ();

	localparam int frame_timeout = 3 * 800 * 525;

	logic        VGA_CLK = 1'b0;
	logic        resetall;
	logic        clockps2;
	logic        data;
	colour_sel_t sw_back;
	colour_sel_t sw_letters;
	chan_t       vga_r;
	chan_t       vga_g;
	chan_t       vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        vga_blank;

	glyph_t      ref_glyphs [glyph_rom_depth];
	scancode_t   model_cells [text_cols*text_rows];
	cell_index_t model_cursor;
	logic        model_break;
	int          stored_keys = 0;
	int          errors = 0;
	int          req_count = 0;
	int          done_count = 0;
	int          started = 0;

	// Checker state.
	logic        hs_prev = 1'b1;
	logic        vs_prev = 1'b1;
	logic        blank_prev = 1'b0;
	logic        hs_seen = 1'b0;
	logic        vs_seen = 1'b0;
	logic        check_on = 1'b0;
	int          x = 0;
	int          y = -1;
	int          h_cyc = 0;
	int          h_low = 0;
	int          lines = 0;
	int          v_low = 0;
	int          act_lines = 0;
	rgb_t        exp_rgb;

	scancode_t keys [36] = '{
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
		8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
		8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h45,
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
	};

	vga_text_top dut0 (.*);

	initial begin
		forever #5 VGA_CLK = ~VGA_CLK;
	end

	// ##########################################################
	// Reference model.
	// ##########################################################
	function automatic rgb_t expected_pixel(input int px, input int py,
	                                        input colour_sel_t back, input colour_sel_t letters);
		colour_sel_t sel;
		glyph_t      g;
		int          bit_pos;
		rgb_t        c;
		sel = back;
		if (px < 400 && py < 120) begin
			g = ref_glyphs[model_cells[(py / 30) * 16 + px / 25][6:0]];
			bit_pos = 29 - ((py % 30) / 5) * 5 - (px % 25) / 5;
			if (g[bit_pos]) sel = letters;
		end
		c.r = sel[2] ? chan_full : '0;
		c.g = sel[1] ? chan_full : '0;
		c.b = sel[0] ? chan_full : '0;
		return c;
	endfunction

	function automatic scancode_t pick_key();
		return keys[$urandom % 36];
	endfunction

	task automatic pick_colours();
		@(negedge VGA_CLK);
		sw_back    = 3'($urandom);
		sw_letters = sw_back ^ 3'($urandom % 7 + 1); // Always differs from background.
	endtask

	// Frame is start, data LSB first, parity, stop.
	task automatic send_key(input scancode_t code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~^code ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(negedge VGA_CLK);
			data = frame[i];
			repeat (20) @(negedge VGA_CLK);
			clockps2 = 1'b0;
			repeat (20) @(negedge VGA_CLK);
			clockps2 = 1'b1;
		end
		repeat (40) @(negedge VGA_CLK);
		data = 1'b1;
		if (!bad_parity) begin
			if (model_break) begin
				model_break = 1'b0;
			end else if (code == break_code) begin
				model_break = 1'b1;
			end else begin
				model_cells[model_cursor] = code;
				model_cursor = model_cursor + 1'b1;
				stored_keys++;
			end
		end
	endtask

	task automatic check_frame();
		int waited;
		waited = 0;
		@(posedge VGA_CLK);
		req_count++;
		while (done_count != req_count && waited < frame_timeout) begin
			@(posedge VGA_CLK);
			waited++;
		end
		if (done_count != req_count) begin
			errors++;
			$display("Timed out waiting for a complete checked frame");
		end
	endtask

	// ##########################################################
	// Checker. Samples outputs on the falling edge.
	// ##########################################################
	always @(negedge VGA_CLK) begin
		h_cyc++;
		if (!vga_hs) h_low++;
		if (hs_prev && !vga_hs) begin
			if (hs_seen && h_cyc != 800) begin
				errors++;
				$display("FAIL vga_hs period %h expected %h", h_cyc, 800);
			end
			hs_seen = 1'b1;
			h_cyc = 0;
			lines++;
			if (!vga_vs) v_low++;
		end
		if (!hs_prev && vga_hs) begin
			if (h_low != 96) begin
				errors++;
				$display("FAIL vga_hs low width %h expected %h", h_low, 96);
			end
			h_low = 0;
		end
		if (vs_prev && !vga_vs) begin
			if (vs_seen && lines != 525) begin
				errors++;
				$display("FAIL vga_vs period in lines %h expected %h", lines, 525);
			end
			vs_seen = 1'b1;
			lines = 0;
		end
		if (!vs_prev && vga_vs) begin
			if (v_low != 2 || act_lines != 480) begin
				errors++;
				$display("FAIL vga_vs low lines %h active lines %h expected %h %h",
				         v_low, act_lines, 2, 480);
			end
			v_low = 0;
			act_lines = 0;
			y = -1;
			if (check_on) begin
				check_on = 1'b0;
				done_count++;
			end
			if (started < req_count) begin
				check_on = 1'b1;
				started++;
			end
		end
		if (vga_blank && !blank_prev) begin
			x = 0;
			y++;
			act_lines++;
		end else if (vga_blank) begin
			x++;
		end
		if (!vga_blank && blank_prev && x != 639) begin
			errors++;
			$display("FAIL vga_blank high width %h expected %h", x + 1, 640);
		end
		if (check_on) begin
			exp_rgb = vga_blank ? expected_pixel(x, y, sw_back, sw_letters) : '0;
			if ({vga_r, vga_g, vga_b} != exp_rgb) begin
				errors++;
				$display("FAIL rgb at x %0d y %0d got %h expected %h",
				         x, y, {vga_r, vga_g, vga_b}, exp_rgb);
			end
		end
		hs_prev = vga_hs;
		vs_prev = vga_vs;
		blank_prev = vga_blank;
	end

	// ##########################################################
	// Stimulus.
	// ##########################################################
	initial begin
		void'($urandom(32'hc1bb_4ee3));
		resetall   = 1'b0;
		clockps2   = 1'b1;
		data       = 1'b1;
		sw_back    = '0;
		sw_letters = '0;
		model_cursor = '0;
		model_break  = 1'b0;
		for (int i = 0; i < text_cols * text_rows; i++) model_cells[i] = '0;
		for (int i = 0; i < glyph_rom_depth; i++) ref_glyphs[i] = '0;
		$readmemh(glyph_file, ref_glyphs);
		repeat (4) @(negedge VGA_CLK);
		resetall = 1'b1;

		repeat (2) begin // Empty buffer.
			pick_colours();
			check_frame();
		end
		repeat (5) send_key(pick_key(), 1'b0);
		check_frame();
		send_key(break_code, 1'b0); // Release pair, then a new key.
		send_key(pick_key(), 1'b0);
		send_key(pick_key(), 1'b0);
		check_frame();
		send_key(pick_key(), 1'b1); // Bad parity.
		check_frame();
		while (stored_keys < 65) send_key(pick_key(), 1'b0); // Cursor wraps to cell 0.
		pick_colours();
		check_frame();

		errors += dut0.chk0.fails;
		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- verification/vga_text_assert.sv
`timescale 1ns/1ps

module vga_text_assert import vga_timing_pkg::*; (
	input logic  VGA_CLK,
	input logic  resetall,
	input logic  vga_hs,
	input logic  vga_blank,
	input chan_t vga_r,
	input chan_t vga_g,
	input chan_t vga_b
);

	coord_t hs_low_len;
	int     fails = 0;

	always_ff @(posedge VGA_CLK) begin
		if (!resetall) hs_low_len <= '0;
		else hs_low_len <= vga_hs ? '0 : hs_low_len + 1'b1;
	end

	// ##########################################################
	// Sync and blanking rules.
	// ##########################################################
	hs_width: assert property (@(posedge VGA_CLK) disable iff (!resetall)
		$rose(vga_hs) |-> hs_low_len == h_sync_end - h_sync_start + 1'b1)
		else begin
			$error("hsync low pulse lasted %0d cycles", hs_low_len);
			fails++;
		end

	blank_in_sync: assert property (@(posedge VGA_CLK) disable iff (!resetall)
		!(vga_blank && !vga_hs))
		else begin
			$error("blank high during hsync pulse");
			fails++;
		end

	rgb_dark: assert property (@(posedge VGA_CLK) disable iff (!resetall)
		!vga_blank |-> {vga_r, vga_g, vga_b} == '0)
		else begin
			$error("colour output nonzero outside active video");
			fails++;
		end

endmodule

bind vga_text_top vga_text_assert chk0 (
	.VGA_CLK,
	.resetall,
	.vga_hs,
	.vga_blank,
	.vga_r,
	.vga_g,
	.vga_b
);
